//--- verilog.f
rtl/pmu_pkg.sv
rtl/pmu_cfg_if.sv
rtl/pmu_regs.sv
rtl/pmu_counters.sv
rtl/pmu_overflow.sv
rtl/pmu_quota_fsm.sv
rtl/pmu_top.sv
tb/tb_pmu.sv

//--- run.sh
#!/bin/sh
# Build and run the PMU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_pmu -o sim_tb_pmu

# Simulation output goes to a log, the verdict comes from the log
./obj_dir/sim_tb_pmu | tee sim.log

grep -q "All tests passed" sim.log

//--- tb/tb_pmu.sv
// PMU testbench

module tb_pmu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = 8;
    localparam int ADDR_W = pmu_pkg::ADDR_W;
    localparam int MAX_CYCLES = 4000;

    // Configuration words built from the field positions
    localparam logic [31:0] EN_W     = 32'h1 << pmu_pkg::CFG_EN_BIT;
    localparam logic [31:0] SRST_W   = 32'h1 << pmu_pkg::CFG_SOFTRST_BIT;
    localparam logic [31:0] OVFEN_W  = 32'h1 << pmu_pkg::CFG_OVF_EN_BIT;
    localparam logic [31:0] OVFRST_W = 32'h1 << pmu_pkg::CFG_OVF_SOFTRST_BIT;
    localparam logic [31:0] QRST_W   = 32'h1 << pmu_pkg::CFG_QUOTA_SOFTRST_BIT;
    localparam logic [31:0] ALL_ON_W  = 32'(pmu_pkg::TEST_ALL_ON) << pmu_pkg::CFG_TEST_LSB;
    localparam logic [31:0] ALL_OFF_W = 32'(pmu_pkg::TEST_ALL_OFF) << pmu_pkg::CFG_TEST_LSB;
    localparam logic [31:0] ONE_ON_W  = 32'(pmu_pkg::TEST_ONE_ON) << pmu_pkg::CFG_TEST_LSB;

    logic              clk_i;
    logic              rst_n_i;
    logic              wr_i;
    logic [ADDR_W-1:0] wr_addr_i;
    logic [31:0]       wr_data_i;
    logic [ADDR_W-1:0] rd_addr_i;
    logic [31:0]       rd_data_o;
    logic [N-1:0]      events_i;
    logic              intr_overflow_o;
    logic              intr_quota_o;

    // Reference counter values
    logic [31:0] exp_cnt [N];
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          cycles;

    pmu_top dut0 (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .wr_i(wr_i), .wr_addr_i(wr_addr_i), .wr_data_i(wr_data_i),
        .rd_addr_i(rd_addr_i), .rd_data_o(rd_data_o),
        .events_i(events_i),
        .intr_overflow_o(intr_overflow_o), .intr_quota_o(intr_quota_o)
    );

    // ------------------------------
    // Clock and run limit
    // ------------------------------
    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // Xorshift step
    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Next rising edge plus drive offset
    task automatic tick();
        @(posedge clk_i);
        #2;
    endtask

    // Single cycle write strobe
    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        wr_i      = 1'b1;
        wr_addr_i = addr;
        wr_data_i = data;
        tick();
        wr_i      = 1'b0;
    endtask

    // Combinational read compared against the model
    task automatic check_reg(input logic [ADDR_W-1:0] addr, input logic [31:0] exp,
                             input string what);
        rd_addr_i = addr;
        #1;
        checks++;
        assert (rd_data_o === exp) else begin
            errors++;
            $display("FAILED at %0t: %s read %h, expected %h", $time, what, rd_data_o, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        #1;
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_counters(input string what);
        for (int k = 0; k < N; k++) begin
            check_reg(ADDR_W'(pmu_pkg::ADDR_COUNTER_BASE + k), exp_cnt[k],
                      $sformatf("%s counter %0d", what, k));
        end
    endtask

    initial begin
        clk_i     = 1'b0;
        rst_n_i   = 1'b0;
        wr_i      = 1'b0;
        wr_addr_i = '0;
        wr_data_i = '0;
        rd_addr_i = '0;
        events_i  = '0;
        rng       = 32'h701e;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        for (int k = 0; k < N; k++) begin
            exp_cnt[k] = '0;
        end
        repeat (5) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        // ------------------------------
        // Reset values and readback
        // ------------------------------
        for (int a = 0; a < 32; a++) begin
            check_reg(ADDR_W'(a), 32'h0, $sformatf("reset address %0d", a));
        end
        write_reg(pmu_pkg::ADDR_CFG, 32'h3fff_ffe0);
        write_reg(pmu_pkg::ADDR_OVF_MASK, 32'ha5a5_5a5a);
        write_reg(pmu_pkg::ADDR_QUOTA_MASK, 32'h1234_5678);
        write_reg(pmu_pkg::ADDR_QUOTA_LIMIT, 32'hdead_beef);
        write_reg(pmu_pkg::ADDR_OVF_VECT, 32'hffff_ffff);
        check_reg(pmu_pkg::ADDR_CFG, 32'h3fff_ffe0, "config");
        check_reg(pmu_pkg::ADDR_OVF_MASK, 32'ha5a5_5a5a, "overflow mask");
        check_reg(pmu_pkg::ADDR_QUOTA_MASK, 32'h1234_5678, "quota mask");
        check_reg(pmu_pkg::ADDR_QUOTA_LIMIT, 32'hdead_beef, "quota limit");
        check_reg(pmu_pkg::ADDR_OVF_VECT, 32'h0, "overflow vector after write");
        write_reg(pmu_pkg::ADDR_OVF_MASK, 32'h0);
        write_reg(pmu_pkg::ADDR_QUOTA_MASK, 32'h0);
        write_reg(pmu_pkg::ADDR_QUOTA_LIMIT, 32'h0);

        // ------------------------------
        // Random event counting
        // ------------------------------
        write_reg(pmu_pkg::ADDR_CFG, EN_W);
        for (int i = 0; i < 200; i++) begin
            rng      = next_random(rng);
            events_i = rng[N-1:0];
            // Counted at the coming edge
            tick();
            for (int k = 0; k < N; k++) begin
                exp_cnt[k] = exp_cnt[k] + 32'(events_i[k]);
            end
        end
        events_i = '0;
        check_counters("random");

        // Load then keep counting
        write_reg(ADDR_W'(pmu_pkg::ADDR_COUNTER_BASE + 3), 32'd1000);
        events_i = 8'h08;
        repeat (5) tick();
        events_i = '0;
        exp_cnt[3] = 32'd1005;
        check_reg(ADDR_W'(pmu_pkg::ADDR_COUNTER_BASE + 3), exp_cnt[3], "loaded counter");

        // Soft reset clears on the second write edge
        write_reg(pmu_pkg::ADDR_CFG, EN_W | SRST_W);
        write_reg(pmu_pkg::ADDR_CFG, EN_W);
        for (int k = 0; k < N; k++) begin
            exp_cnt[k] = '0;
        end
        check_counters("soft reset");

        // ------------------------------
        // Test modes, 50 edges each
        // ------------------------------
        write_reg(pmu_pkg::ADDR_CFG, EN_W | ALL_ON_W);
        repeat (49) tick();
        // Mode change edge still counts the old mode
        write_reg(pmu_pkg::ADDR_CFG, EN_W | ALL_OFF_W);
        for (int k = 0; k < N; k++) begin
            exp_cnt[k] = 32'd50;
        end
        check_counters("all on");
        repeat (49) tick();
        write_reg(pmu_pkg::ADDR_CFG, EN_W | ONE_ON_W);
        check_counters("all off");
        repeat (49) tick();
        write_reg(pmu_pkg::ADDR_CFG, 32'h0);
        exp_cnt[0] = 32'd100;
        check_counters("one on");

        // ------------------------------
        // Overflow
        // ------------------------------
        write_reg(pmu_pkg::ADDR_OVF_MASK, 32'h4);
        write_reg(ADDR_W'(pmu_pkg::ADDR_COUNTER_BASE + 2), 32'hffff_ffff);
        write_reg(pmu_pkg::ADDR_CFG, EN_W | OVFEN_W);
        events_i = 8'h04;
        tick();
        events_i = '0;
        check_reg(ADDR_W'(pmu_pkg::ADDR_COUNTER_BASE + 2), 32'h0, "wrapped counter");
        check_reg(pmu_pkg::ADDR_OVF_VECT, 32'h4, "overflow vector");
        check_bit(intr_overflow_o, 1'b1, "overflow interrupt");
        write_reg(pmu_pkg::ADDR_OVF_MASK, 32'h0);
        check_bit(intr_overflow_o, 1'b0, "masked overflow interrupt");
        // Bit still held after the wrap cycle
        check_reg(pmu_pkg::ADDR_OVF_VECT, 32'h4, "overflow vector held");
        write_reg(pmu_pkg::ADDR_CFG, EN_W | OVFEN_W | OVFRST_W);
        write_reg(pmu_pkg::ADDR_CFG, EN_W | OVFEN_W);
        check_reg(pmu_pkg::ADDR_OVF_VECT, 32'h0, "overflow vector after clear");

        // ------------------------------
        // Quota
        // ------------------------------
        // Scanner held in restart while set up
        write_reg(pmu_pkg::ADDR_CFG, QRST_W);
        for (int k = 0; k < N; k++) begin
            write_reg(ADDR_W'(pmu_pkg::ADDR_COUNTER_BASE + k), 32'd100 * 32'(k + 1));
        end
        // Counters 1 and 4 sum to 700
        write_reg(pmu_pkg::ADDR_QUOTA_MASK, 32'h12);
        write_reg(pmu_pkg::ADDR_QUOTA_LIMIT, 32'd600);
        write_reg(pmu_pkg::ADDR_CFG, 32'h0);
        repeat (2 * (N + 1)) tick();
        check_bit(intr_quota_o, 1'b1, "quota interrupt over limit");
        write_reg(pmu_pkg::ADDR_CFG, QRST_W);
        write_reg(pmu_pkg::ADDR_QUOTA_LIMIT, 32'd800);
        check_bit(intr_quota_o, 1'b0, "quota interrupt after clear");
        write_reg(pmu_pkg::ADDR_CFG, 32'h0);
        repeat (2 * (N + 1)) tick();
        check_bit(intr_quota_o, 1'b0, "quota interrupt under limit");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- rtl/pmu_top.sv
// PMU top level

module pmu_top #(
    parameter int unsigned REG_WIDTH  = 32,
    parameter int unsigned N_COUNTERS = 8
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    // Register port
    input  logic                       wr_i,
    input  logic [pmu_pkg::ADDR_W-1:0] wr_addr_i,
    input  logic [REG_WIDTH-1:0]       wr_data_i,
    input  logic [pmu_pkg::ADDR_W-1:0] rd_addr_i,
    output logic [REG_WIDTH-1:0]       rd_data_o,
    // Monitored events
    input  logic [N_COUNTERS-1:0]      events_i,
    // Interrupts
    output logic                       intr_overflow_o,
    output logic                       intr_quota_o
);

    // ----------------------------
    // Internal wiring
    // ----------------------------
    logic [N_COUNTERS-1:0] load;
    logic [REG_WIDTH-1:0]  load_data;
    logic [REG_WIDTH-1:0]  counter_values [N_COUNTERS];
    logic [N_COUNTERS-1:0] wrap;
    logic [N_COUNTERS-1:0] ovf_vect;

    // Decoded configuration bus
    pmu_cfg_if #(.N_COUNTERS(N_COUNTERS), .REG_WIDTH(REG_WIDTH)) cfg_bus ();

    // ----------------------------
    // Instances
    // ----------------------------
    pmu_regs #(.REG_WIDTH(REG_WIDTH), .N_COUNTERS(N_COUNTERS)) u_regs (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .wr_i(wr_i), .wr_addr_i(wr_addr_i), .wr_data_i(wr_data_i),
        .rd_addr_i(rd_addr_i), .rd_data_o(rd_data_o),
        .cfg(cfg_bus.regs_mp),
        .load_o(load), .load_data_o(load_data),
        .counter_values_i(counter_values), .ovf_vect_i(ovf_vect)
    );

    pmu_counters #(.REG_WIDTH(REG_WIDTH), .N_COUNTERS(N_COUNTERS)) u_counters (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .cfg(cfg_bus.counters_mp),
        .events_i(events_i), .load_i(load), .load_data_i(load_data),
        .values_o(counter_values), .wrap_o(wrap)
    );

    pmu_overflow #(.N_COUNTERS(N_COUNTERS)) u_overflow (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .cfg(cfg_bus.overflow_mp),
        .wrap_i(wrap), .vect_o(ovf_vect), .intr_overflow_o(intr_overflow_o)
    );

    pmu_quota_fsm #(.REG_WIDTH(REG_WIDTH), .N_COUNTERS(N_COUNTERS)) u_quota (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .cfg(cfg_bus.quota_mp),
        .counter_values_i(counter_values), .intr_quota_o(intr_quota_o)
    );

endmodule

//--- rtl/pmu_quota_fsm.sv
// PMU quota scanner

module pmu_quota_fsm #(
    parameter int unsigned REG_WIDTH  = 32,
    parameter int unsigned N_COUNTERS = 8
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    pmu_cfg_if.quota_mp          cfg,
    input  logic [REG_WIDTH-1:0] counter_values_i [N_COUNTERS],
    output logic                 intr_quota_o
);

    localparam int unsigned IDX_W = $clog2(N_COUNTERS);
    localparam int unsigned SUM_W = REG_WIDTH + pmu_pkg::SUM_EXTRA;

    // Scan states
    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        COMPARE
    } state_t;

    state_t           state_q;
    logic [IDX_W-1:0] idx_q;
    logic [SUM_W-1:0] sum_q;
    // Counter under the index after masking
    logic [REG_WIDTH-1:0] masked_val;

    assign masked_val = cfg.quota_mask[idx_q] ? counter_values_i[idx_q] : '0;

    // ----------------------------
    // Scan FSM
    // ----------------------------
    // N_COUNTERS scan cycles plus one compare
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            idx_q        <= '0;
            sum_q        <= '0;
            intr_quota_o <= 1'b0;
        end else if (cfg.quota_softrst) begin
            // Restart and drop the flag
            state_q      <= IDLE;
            idx_q        <= '0;
            sum_q        <= '0;
            intr_quota_o <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    state_q <= SCAN;
                end
                SCAN: begin
                    sum_q <= sum_q + SUM_W'(masked_val);
                    if (idx_q == IDX_W'(N_COUNTERS - 1)) begin
                        idx_q   <= '0;
                        state_q <= COMPARE;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                COMPARE: begin
                    // Flag is sticky until soft reset
                    if (sum_q > SUM_W'(cfg.quota_limit)) begin
                        intr_quota_o <= 1'b1;
                    end
                    sum_q   <= '0;
                    state_q <= SCAN;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

//--- rtl/pmu_overflow.sv
// PMU overflow interrupt

module pmu_overflow #(
    parameter int unsigned N_COUNTERS = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    pmu_cfg_if.overflow_mp        cfg,
    // One pulse per counter wrap
    input  logic [N_COUNTERS-1:0] wrap_i,
    output logic [N_COUNTERS-1:0] vect_o,
    output logic                  intr_overflow_o
);

    // ----------------------------
    // Sticky wrap vector
    // ----------------------------
    // Set on the same edge as the wrap
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vect_o <= '0;
        end else if (cfg.ovf_softrst) begin
            vect_o <= '0;
        end else if (cfg.ovf_en) begin
            vect_o <= vect_o | wrap_i;
        end
    end

    // ----------------------------
    // Interrupt
    // ----------------------------
    // Any unmasked sticky bit
    assign intr_overflow_o = |(vect_o & cfg.ovf_mask);

endmodule

//--- rtl/pmu_counters.sv
// PMU event counter bank

module pmu_counters #(
    parameter int unsigned REG_WIDTH  = 32,
    parameter int unsigned N_COUNTERS = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    pmu_cfg_if.counters_mp        cfg,
    // Raw event lines
    input  logic [N_COUNTERS-1:0] events_i,
    // Software load path
    input  logic [N_COUNTERS-1:0] load_i,
    input  logic [REG_WIDTH-1:0]  load_data_i,
    // Counter state and wrap pulses
    output logic [REG_WIDTH-1:0]  values_o [N_COUNTERS],
    output logic [N_COUNTERS-1:0] wrap_o
);

    // Events after the test override
    logic [N_COUNTERS-1:0] events_eff;

    // ----------------------------
    // Test pattern select
    // ----------------------------
    always_comb begin
        case (cfg.test_mode)
            pmu_pkg::TEST_ALL_ON:  events_eff = '1;
            pmu_pkg::TEST_ALL_OFF: events_eff = '0;
            // Only event 0 active
            pmu_pkg::TEST_ONE_ON:  events_eff = {{(N_COUNTERS-1){1'b0}}, 1'b1};
            default:               events_eff = events_i;
        endcase
    end

    // ----------------------------
    // Counters
    // ----------------------------
    // Priority is load then soft reset then count
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < N_COUNTERS; k++) begin
                values_o[k] <= '0;
            end
        end else begin
            for (int k = 0; k < N_COUNTERS; k++) begin
                if (load_i[k]) begin
                    values_o[k] <= load_data_i;
                end else if (cfg.softrst) begin
                    values_o[k] <= '0;
                end else if (cfg.en && events_eff[k]) begin
                    values_o[k] <= values_o[k] + 1'b1;
                end
            end
        end
    end

    // Wrap pulse only when the increment really happens
    always_comb begin
        for (int k = 0; k < N_COUNTERS; k++) begin
            wrap_o[k] = cfg.en && events_eff[k] && (&values_o[k])
                        && !load_i[k] && !cfg.softrst;
        end
    end

endmodule

//--- rtl/pmu_regs.sv
// PMU software register block

module pmu_regs #(
    parameter int unsigned REG_WIDTH  = 32,
    parameter int unsigned N_COUNTERS = 8
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // Write port
    input  logic                        wr_i,
    input  logic [pmu_pkg::ADDR_W-1:0]  wr_addr_i,
    input  logic [REG_WIDTH-1:0]        wr_data_i,
    // Read port
    input  logic [pmu_pkg::ADDR_W-1:0]  rd_addr_i,
    output logic [REG_WIDTH-1:0]        rd_data_o,
    // Decoded configuration
    pmu_cfg_if.regs_mp                  cfg,
    // Counter load path
    output logic [N_COUNTERS-1:0]       load_o,
    output logic [REG_WIDTH-1:0]        load_data_o,
    // Status from the function blocks
    input  logic [REG_WIDTH-1:0]        counter_values_i [N_COUNTERS],
    input  logic [N_COUNTERS-1:0]       ovf_vect_i
);

    // Stored registers
    logic [REG_WIDTH-1:0]  cfg_q;
    logic [REG_WIDTH-1:0]  ovf_mask_q;
    logic [REG_WIDTH-1:0]  quota_mask_q;
    logic [REG_WIDTH-1:0]  quota_limit_q;
    // One bit per counter address on the read side
    logic [N_COUNTERS-1:0] rd_hit;

    // ----------------------------
    // Write decode
    // ----------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_q         <= '0;
            ovf_mask_q    <= '0;
            quota_mask_q  <= '0;
            quota_limit_q <= '0;
        end else if (wr_i) begin
            // Vector address is read only
            case (wr_addr_i)
                pmu_pkg::ADDR_CFG:         cfg_q         <= wr_data_i;
                pmu_pkg::ADDR_OVF_MASK:    ovf_mask_q    <= wr_data_i;
                pmu_pkg::ADDR_QUOTA_MASK:  quota_mask_q  <= wr_data_i;
                pmu_pkg::ADDR_QUOTA_LIMIT: quota_limit_q <= wr_data_i;
                default: ;
            endcase
        end
    end

    // Counter range decode for loads and reads
    for (genvar k = 0; k < N_COUNTERS; k++) begin : g_cnt_addr
        localparam logic [pmu_pkg::ADDR_W-1:0] CNT_ADDR = pmu_pkg::ADDR_COUNTER_BASE + k;
        assign load_o[k] = wr_i && (wr_addr_i == CNT_ADDR);
        assign rd_hit[k] = (rd_addr_i == CNT_ADDR);
    end

    // Same data bus for every counter load
    assign load_data_o = wr_data_i;

    // ----------------------------
    // Field extraction
    // ----------------------------
    assign cfg.en            = cfg_q[pmu_pkg::CFG_EN_BIT];
    assign cfg.softrst       = cfg_q[pmu_pkg::CFG_SOFTRST_BIT];
    assign cfg.test_mode     = pmu_pkg::test_mode_t'(cfg_q[pmu_pkg::CFG_TEST_LSB +: 2]);
    assign cfg.ovf_en        = cfg_q[pmu_pkg::CFG_OVF_EN_BIT];
    assign cfg.ovf_softrst   = cfg_q[pmu_pkg::CFG_OVF_SOFTRST_BIT];
    assign cfg.ovf_mask      = ovf_mask_q[N_COUNTERS-1:0];
    assign cfg.quota_softrst = cfg_q[pmu_pkg::CFG_QUOTA_SOFTRST_BIT];
    assign cfg.quota_mask    = quota_mask_q[N_COUNTERS-1:0];
    assign cfg.quota_limit   = quota_limit_q;

    // ----------------------------
    // Read mux
    // ----------------------------
    always_comb begin
        case (rd_addr_i)
            pmu_pkg::ADDR_CFG:         rd_data_o = cfg_q;
            pmu_pkg::ADDR_OVF_MASK:    rd_data_o = ovf_mask_q;
            pmu_pkg::ADDR_OVF_VECT:    rd_data_o = {{(REG_WIDTH-N_COUNTERS){1'b0}}, ovf_vect_i};
            pmu_pkg::ADDR_QUOTA_MASK:  rd_data_o = quota_mask_q;
            pmu_pkg::ADDR_QUOTA_LIMIT: rd_data_o = quota_limit_q;
            default:                   rd_data_o = '0;
        endcase
        // Counter window overrides the zero default
        for (int k = 0; k < N_COUNTERS; k++) begin
            if (rd_hit[k]) begin
                rd_data_o = counter_values_i[k];
            end
        end
    end

endmodule

//--- rtl/pmu_cfg_if.sv
// PMU configuration bus

interface pmu_cfg_if #(
    parameter int unsigned N_COUNTERS = 8,
    parameter int unsigned REG_WIDTH  = 32
);

    // Counter bank controls
    logic                 en;
    logic                 softrst;
    pmu_pkg::test_mode_t  test_mode;

    // Overflow controls
    logic                  ovf_en;
    logic                  ovf_softrst;
    logic [N_COUNTERS-1:0] ovf_mask;

    // Quota controls
    logic                  quota_softrst;
    logic [N_COUNTERS-1:0] quota_mask;
    logic [REG_WIDTH-1:0]  quota_limit;

    // Register block is the only driver
    modport regs_mp (
        output en, softrst, test_mode, ovf_en, ovf_softrst, ovf_mask,
        output quota_softrst, quota_mask, quota_limit
    );
    modport counters_mp (input en, softrst, test_mode);
    modport overflow_mp (input ovf_en, ovf_softrst, ovf_mask);
    modport quota_mp (input quota_softrst, quota_mask, quota_limit);

endinterface

//--- rtl/pmu_pkg.sv
// PMU shared definitions

package pmu_pkg;

    // ----------------------------
    // Register map
    // ----------------------------

    // Register address width
    localparam int unsigned ADDR_W = 5;

    // Fixed control and status registers
    localparam logic [ADDR_W-1:0] ADDR_CFG         = 5'd0;
    localparam logic [ADDR_W-1:0] ADDR_OVF_MASK    = 5'd1;
    localparam logic [ADDR_W-1:0] ADDR_OVF_VECT    = 5'd2;
    localparam logic [ADDR_W-1:0] ADDR_QUOTA_MASK  = 5'd3;
    localparam logic [ADDR_W-1:0] ADDR_QUOTA_LIMIT = 5'd4;

    // Counter k lives at base plus k
    localparam logic [ADDR_W-1:0] ADDR_COUNTER_BASE = 5'd5;

    // ----------------------------
    // Configuration register fields
    // ----------------------------
    localparam int unsigned CFG_EN_BIT            = 0;
    localparam int unsigned CFG_SOFTRST_BIT       = 1;
    localparam int unsigned CFG_OVF_EN_BIT        = 2;
    localparam int unsigned CFG_OVF_SOFTRST_BIT   = 3;
    localparam int unsigned CFG_QUOTA_SOFTRST_BIT = 4;

    // Two bit test field sits at the top
    localparam int unsigned CFG_TEST_LSB = 30;

    // Event override patterns
    typedef enum logic [1:0] {
        TEST_OFF     = 2'b00,
        TEST_ALL_ON  = 2'b01,
        TEST_ALL_OFF = 2'b10,
        TEST_ONE_ON  = 2'b11
    } test_mode_t;

    // Headroom bits of the quota accumulator
    localparam int unsigned SUM_EXTRA = 4;

endpackage
